//--- flist.f
+incdir+design
design/avalon_pkg.sv
design/dma_pkg.sv
design/avalon_mm_if.sv
design/sync_fifo.sv
design/desc_dispatcher.sv
design/wr_burst_master.sv
design/dma_write_top.sv
sim/dma_write_assertions.sv
sim/tb_dma_write.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 -f flist.f --top-module tb_dma_write -o tb_dma_write \
    && ./obj_dir/tb_dma_write +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
grep -q '^>>> FAIL' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '^>>> PASS' sim.log || { echo "simulation ended without a result line"; exit 1; }

//--- sim/tb_dma_write.sv
module tb_dma_write;
    timeunit 1ns;
    timeprecision 100ps;
    import avalon_pkg::*;

    localparam logic [31:0] lfsr_seed  = 32'hb32b_9d74;
    localparam int          wait_limit = 2000; // cycles that any one wait may take

    logic        clk = 1'b0;
    logic        reset = 1'b0;
    logic        desc_push = 1'b0;
    logic [31:0] desc_control = '0;
    logic [31:0] desc_pkt_begin = '0;
    logic [31:0] desc_pkt_end = '0;
    logic [31:0] desc_write_address = '0;
    logic        data_push = 1'b0;
    bus_word_t   data_in = '0;
    logic        avm_waitrequest = 1'b0;
    logic        desc_full, data_full, avm_write, busy, done_irq;
    bus_addr_t   avm_address;
    bus_word_t   avm_writedata;
    burst_cnt_t  avm_burstcount;
    logic [15:0] xfer_count, drop_count;

    logic [31:0] data_state = lfsr_seed;
    logic [31:0] wait_state = lfsr_seed; // the waitrequest stream steps its own copy
    logic        wait_en = 1'b0;
    bus_word_t   mem [bus_addr_t];        // slave memory keyed by byte address
    bus_word_t   exp_word [$];
    bus_addr_t   exp_addr [$];
    int          beat_idx = 0;
    int          total_beats = 0;
    int          irq_count = 0;
    int          exp_xfers = 0;
    int          exp_drops = 0;
    int          exp_irqs = 0;
    int          test_errors = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          tests = 0;
    int          beats0 = 0;
    logic        timed_out = 1'b0;
    string       cur_test;

    dma_write_top u_dut (
        .clk(clk), .reset(reset),
        .desc_push(desc_push), .desc_control(desc_control), .desc_pkt_begin(desc_pkt_begin),
        .desc_pkt_end(desc_pkt_end), .desc_write_address(desc_write_address),
        .desc_full(desc_full), .data_push(data_push), .data_in(data_in), .data_full(data_full),
        .avm_address(avm_address), .avm_writedata(avm_writedata), .avm_write(avm_write),
        .avm_burstcount(avm_burstcount), .avm_waitrequest(avm_waitrequest),
        .busy(busy), .done_irq(done_irq), .xfer_count(xfer_count), .drop_count(drop_count)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic bus_word_t rand_word();
        bus_word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            data_state = lfsr_step(data_state);
            w = {w[30:0], data_state[0]}; // one new bit per step
        end
        return w;
    endfunction

    always @(posedge clk) begin
        wait_state      <= lfsr_step(wait_state);
        avm_waitrequest <= wait_en && wait_state[0];
    end

    // slave model, each beat lands one word further on from the burst address
    always @(posedge clk) begin
        if (reset && avm_write && !avm_waitrequest) begin
            mem[avm_address + 32'(beat_idx * 4)] = avm_writedata;
            total_beats <= total_beats + 1;
            beat_idx    <= (beat_idx + 1 == int'(avm_burstcount)) ? 0 : beat_idx + 1;
        end
        if (done_irq) begin
            irq_count <= irq_count + 1;
        end
    end

    task automatic note_timeout(input string what);
        $display("%s: timed out waiting for %s", cur_test, what);
        timed_out = 1'b1;
        test_errors++;
    endtask

    task automatic push_desc(input logic [31:0] control, pbeg, pend, addr);
        int n;
        n = 0;
        while (!timed_out && desc_full) begin
            @(posedge clk);
            n++;
            if (n > wait_limit) note_timeout("room in the descriptor queue");
        end
        if (!timed_out) begin
            desc_push          <= 1'b1;
            desc_control       <= control;
            desc_pkt_begin     <= pbeg;
            desc_pkt_end       <= pend;
            desc_write_address <= addr;
            @(posedge clk);
            desc_push <= 1'b0;
            @(posedge clk); // desc_full now includes this push
        end
    endtask

    // words go in every other cycle, so the writer drains the FIFO faster than it fills
    task automatic push_words(input bus_addr_t addr, input int count);
        int n;
        for (int i = 0; i < count && !timed_out; i++) begin
            n = 0;
            while (!timed_out && data_full) begin
                @(posedge clk);
                n++;
                if (n > wait_limit) note_timeout("room in the data FIFO");
            end
            exp_word.push_back(rand_word());
            exp_addr.push_back(addr + 32'(i * 4));
            data_push <= 1'b1;
            data_in   <= exp_word[exp_word.size() - 1];
            @(posedge clk);
            data_push <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic wait_counts();
        int n;
        n = 0;
        while (!timed_out && (int'(xfer_count) != exp_xfers || int'(drop_count) != exp_drops)) begin
            @(posedge clk);
            n++;
            if (n > wait_limit) note_timeout("the transfer and drop counts");
        end
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        assert (act == exp) else begin
            $display("** Error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_words();
        bus_word_t got;
        for (int i = 0; i < exp_word.size(); i++) begin
            got = mem.exists(exp_addr[i]) ? mem[exp_addr[i]] : '0;
            assert (mem.exists(exp_addr[i]) && got == exp_word[i]) else begin
                $display("** Error %s: word at %h expected %h actual %h",
                         cur_test, exp_addr[i], exp_word[i], got);
                test_errors++;
            end
        end
        exp_word.delete();
        exp_addr.delete();
        check_value("xfer_count", exp_xfers, int'(xfer_count));
        check_value("drop_count", exp_drops, int'(drop_count));
        check_value("done_irq pulses", exp_irqs, irq_count);
    endtask

    task automatic finish_test();
        $display("test %s: %0d errors", cur_test, test_errors);
        tests++;
        errors += test_errors;
        if (test_errors != 0) failed_tests++;
        test_errors = 0;
    endtask

    initial begin
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);

        cur_test = "single_burst";
        push_desc(32'h0, 32'h0, 32'd32, 32'h1000);
        push_words(32'h1000, 8);
        exp_xfers++;
        wait_counts();
        check_words();
        finish_test();

        cur_test = "waitrequest";
        wait_en <= 1'b1;
        push_desc(32'h0, 32'h40, 32'hc0, 32'h2000);
        push_words(32'h2000, 32);
        exp_xfers++;
        wait_counts();
        wait_en <= 1'b0;
        check_words();
        finish_test();

        cur_test = "bad_desc";
        beats0 = total_beats;
        push_words(32'h4000, 4); // a wrongly started descriptor would find data to write
        push_desc(32'h0, 32'h20, 32'h20, 32'h4000);  // zero length
        push_desc(32'h0, 32'h2, 32'h22, 32'h4000);   // unaligned begin
        push_desc(32'h0, 32'h0, 32'd1024, 32'h4000); // 256 words
        exp_drops += 3;
        wait_counts();
        check_value("beats", beats0, total_beats);
        push_desc(32'h0, 32'h0, 32'd16, 32'h4000); // the queued words go out with this one
        exp_xfers++;
        wait_counts();
        check_words();
        finish_test();

        cur_test = "irq";
        push_desc(32'h1, 32'h0, 32'd16, 32'h5000);
        push_words(32'h5000, 4);
        exp_xfers++;
        exp_irqs++;
        wait_counts();
        push_desc(32'h0, 32'h0, 32'd16, 32'h5100);
        push_words(32'h5100, 4);
        exp_xfers++;
        wait_counts();
        check_words();
        finish_test();

        cur_test = "queued";
        push_desc(32'h0, 32'h0, 32'd24, 32'h6000);
        push_desc(32'h0, 32'h100, 32'h128, 32'h6100);
        push_desc(32'h0, 32'h0, 32'd20, 32'h6200);
        repeat (10) @(posedge clk);
        push_words(32'h6000, 6);
        push_words(32'h6100, 10);
        push_words(32'h6200, 5);
        exp_xfers += 3;
        wait_counts();
        check_words();
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests, failed_tests, errors, u_dut.u_assertions.failures);
        if (errors == 0 && !timed_out && u_dut.u_assertions.failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/dma_write_assertions.sv
module dma_write_assertions (
    input logic                   clk,
    input logic                   reset,
    input avalon_pkg::bus_addr_t  avm_address,
    input avalon_pkg::bus_word_t  avm_writedata,
    input logic                   avm_write,
    input avalon_pkg::burst_cnt_t avm_burstcount,
    input logic                   avm_waitrequest,
    input logic                   start,
    input dma_pkg::wr_desc_t      start_desc,
    input logic                   wr_done,
    input logic                   done_irq,
    input logic                   busy
);
    timeunit 1ns;
    timeprecision 100ps;
    import avalon_pkg::*;
    import dma_pkg::*;

    burst_cnt_t beats;   // beats accepted since the current burst began
    logic       irq_req; // control bit of the descriptor in flight
    int         hold_fails = 0;
    int         stable_fails = 0;
    int         count_fails = 0;
    int         irq_fails = 0;
    int         busy_fails = 0;
    int         failures;

    always_comb failures = hold_fails + stable_fails + count_fails + irq_fails + busy_fails;

    always_ff @(posedge clk) begin
        if (!reset) begin
            beats   <= '0;
            irq_req <= 1'b0;
        end else begin
            if (wr_done) begin
                beats <= '0;
            end else if (avm_write && !avm_waitrequest) begin
                beats <= beats + 1'b1;
            end
            if (start) begin
                irq_req <= start_desc.control[CTRL_IRQ_EN];
            end
        end
    end

    // a stalled beat must come back unchanged on the next cycle
    a_hold: assert property (@(posedge clk) disable iff (!reset)
        avm_write && avm_waitrequest |=> avm_write && $stable(avm_writedata)
            && $stable(avm_address) && $stable(avm_burstcount))
    else begin
        hold_fails = hold_fails + 1;
        $error("write beat changed while waitrequest was high");
    end

    a_stable: assert property (@(posedge clk) disable iff (!reset)
        beats != '0 |-> $stable(avm_address) && $stable(avm_burstcount))
    else begin
        stable_fails = stable_fails + 1;
        $error("address or burstcount moved inside a burst");
    end

    a_count: assert property (@(posedge clk) disable iff (!reset)
        wr_done |-> beats == avm_burstcount)
    else begin
        count_fails = count_fails + 1;
        $error("burst ended after %0d beats, burstcount %0d", beats, avm_burstcount);
    end

    a_irq: assert property (@(posedge clk) disable iff (!reset)
        done_irq || wr_done |-> wr_done && (done_irq == irq_req))
    else begin
        irq_fails = irq_fails + 1;
        $error("done_irq does not match the control word of the transfer");
    end

    // busy stays high from the cycle after start until the cycle after the last beat
    a_busy: assert property (@(posedge clk) disable iff (!reset)
        start || avm_write |=> busy)
    else begin
        busy_fails = busy_fails + 1;
        $error("busy was low while a transfer was in progress");
    end

endmodule

bind dma_write_top dma_write_assertions u_assertions (
    .clk(clk), .reset(reset),
    .avm_address(avm_address), .avm_writedata(avm_writedata), .avm_write(avm_write),
    .avm_burstcount(avm_burstcount), .avm_waitrequest(avm_waitrequest),
    .start(start), .start_desc(start_desc), .wr_done(wr_done), .done_irq(done_irq),
    .busy(busy)
);

//--- design/dma_write_top.sv
`include "dma_macros.svh"

module dma_write_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   desc_push,
    input  logic [31:0]            desc_control,
    input  logic [31:0]            desc_pkt_begin,
    input  logic [31:0]            desc_pkt_end,
    input  logic [31:0]            desc_write_address,
    output logic                   desc_full,
    input  logic                   data_push,
    input  avalon_pkg::bus_word_t  data_in,
    output logic                   data_full,
    output avalon_pkg::bus_addr_t  avm_address,
    output avalon_pkg::bus_word_t  avm_writedata,
    output logic                   avm_write,
    output avalon_pkg::burst_cnt_t avm_burstcount,
    input  logic                   avm_waitrequest,
    output logic                   busy,
    output logic                   done_irq,
    output logic [15:0]            xfer_count,
    output logic [15:0]            drop_count
);
    import avalon_pkg::*;
    import dma_pkg::*;

    wr_desc_t  desc_in;
    wr_desc_t  desc_q;
    wr_desc_t  start_desc;
    logic      desc_pop;
    logic      desc_empty;
    logic      data_pop;
    logic      data_empty;
    bus_word_t data_q;
    logic      start;
    logic      wr_done;

    avalon_mm_if avm_bus ();

    assign desc_in = '{control:       desc_control,
                       pkt_begin:     desc_pkt_begin,
                       pkt_end:       desc_pkt_end,
                       write_address: desc_write_address};

    // host side of the bus goes out as plain ports
    assign avm_address         = avm_bus.address;
    assign avm_writedata       = avm_bus.writedata;
    assign avm_write           = avm_bus.write;
    assign avm_burstcount      = avm_bus.burstcount;
    assign avm_bus.waitrequest = avm_waitrequest;

    sync_fifo #(.payload_t(wr_desc_t), .depth_log2(`DESC_FIFO_LOG2)) u_desc_fifo (
        .clk(clk), .reset(reset),
        .push(desc_push), .din(desc_in), .full(desc_full),
        .pop(desc_pop), .dout(desc_q), .empty(desc_empty)
    );

    sync_fifo #(.payload_t(bus_word_t), .depth_log2(`DATA_FIFO_LOG2)) u_data_fifo (
        .clk(clk), .reset(reset),
        .push(data_push), .din(data_in), .full(data_full),
        .pop(data_pop), .dout(data_q), .empty(data_empty)
    );

    desc_dispatcher u_dispatcher (
        .clk(clk), .reset(reset),
        .desc_empty(desc_empty), .desc_pop(desc_pop), .desc(desc_q),
        .wr_busy(busy), .wr_done(wr_done),
        .start(start), .start_desc(start_desc),
        .xfer_count(xfer_count), .drop_count(drop_count)
    );

    wr_burst_master u_writer (
        .clk(clk), .reset(reset),
        .start(start), .start_desc(start_desc),
        .busy(busy), .done(wr_done), .done_irq(done_irq),
        .data_pop(data_pop), .data_empty(data_empty), .data_q(data_q),
        .avm(avm_bus.master)
    );

endmodule

//--- design/wr_burst_master.sv
module wr_burst_master (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  dma_pkg::wr_desc_t     start_desc,
    output logic                  busy,
    output logic                  done,
    output logic                  done_irq,
    output logic                  data_pop,
    input  logic                  data_empty,
    input  avalon_pkg::bus_word_t data_q,
    avalon_mm_if.master           avm
);
    import avalon_pkg::*;
    import dma_pkg::*;

    wr_state_t   state;
    bus_addr_t   addr_q;
    burst_cnt_t  burst_q;
    burst_cnt_t  fetch_left; // words still to be taken from the data FIFO
    burst_cnt_t  beats_left; // beats the slave has yet to accept
    logic        irq_q;
    bus_word_t   hold_data;
    logic        hold_valid;
    logic        pend;       // a popped word sits on the FIFO output
    logic        accept;
    logic        move;
    logic [31:0] byte_len;
    burst_cnt_t  word_cnt;

    assign byte_len = start_desc.pkt_end - start_desc.pkt_begin;
    assign word_cnt = burst_cnt_t'(byte_len / BYTES_PER_WORD);

    // address and burstcount are set once per burst and stay put until the last beat
    assign avm.address    = addr_q;
    assign avm.burstcount = burst_q;
    assign avm.write      = hold_valid;
    assign avm.writedata  = hold_data;

    assign accept = hold_valid && !avm.waitrequest;

    // the pending word moves into the holding register once that register frees up
    assign move = pend && (!hold_valid || accept);

    // at most one word waits on the FIFO output while another waits on the bus
    assign data_pop = (state == st_run) && (fetch_left != '0) && !data_empty
                   && (!pend || move);

    assign busy     = (state != st_idle);
    assign done     = (state == st_done);
    assign done_irq = done && irq_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= st_idle;
            fetch_left <= '0;
            beats_left <= '0;
            irq_q      <= 1'b0;
            hold_valid <= 1'b0;
            pend       <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state      <= st_run;
                        fetch_left <= word_cnt;
                        beats_left <= word_cnt;
                        irq_q      <= start_desc.control[CTRL_IRQ_EN];
                    end
                end
                st_run: begin
                    if (data_pop) begin
                        fetch_left <= fetch_left - 1'b1;
                    end
                    if (accept) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == burst_cnt_t'(1)) begin
                            state <= st_done; // last beat went out
                        end
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase

            if (move) begin
                hold_valid <= 1'b1;
            end else if (accept) begin
                hold_valid <= 1'b0;
            end

            if (data_pop) begin
                pend <= 1'b1; // a new word replaces the one moving, if any
            end else if (move) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            addr_q  <= start_desc.write_address;
            burst_q <= word_cnt;
        end
        if (move) begin
            hold_data <= data_q;
        end
    end

endmodule

//--- design/desc_dispatcher.sv
`include "dma_macros.svh"

module desc_dispatcher (
    input  logic              clk,
    input  logic              reset,
    input  logic              desc_empty,
    output logic              desc_pop,
    input  dma_pkg::wr_desc_t desc,
    input  logic              wr_busy,
    input  logic              wr_done,
    output logic              start,
    output dma_pkg::wr_desc_t start_desc,
    output logic [15:0]       xfer_count,
    output logic [15:0]       drop_count
);

    typedef enum logic [1:0] {
        disp_idle,
        disp_check, // popped descriptor is on the FIFO output
        disp_wait   // writer owns the transfer until its done pulse
    } disp_state_t;

    disp_state_t state;
    logic [31:0] byte_len;
    logic        desc_ok;

    assign byte_len = desc.pkt_end - desc.pkt_begin;

    // at least one word, both offsets on word boundaries, and small enough for one burst
    assign desc_ok = (desc.pkt_end > desc.pkt_begin)
                  && (desc.pkt_begin[1:0] == 2'b00)
                  && (desc.pkt_end[1:0] == 2'b00)
                  && (byte_len <= `MAX_BURST * 4);

    assign desc_pop = (state == disp_idle) && !wr_busy && !desc_empty;

    // the FIFO holds its output until the next pop, so the writer can latch it straight
    assign start      = (state == disp_check) && desc_ok;
    assign start_desc = desc;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= disp_idle;
            xfer_count <= '0;
            drop_count <= '0;
        end else begin
            case (state)
                disp_idle: begin
                    if (desc_pop) begin
                        state <= disp_check;
                    end
                end
                disp_check: begin
                    if (desc_ok) begin
                        state <= disp_wait;
                    end else begin
                        drop_count <= drop_count + 16'd1; // malformed, nothing reaches the bus
                        state      <= disp_idle;
                    end
                end
                disp_wait: begin
                    if (wr_done) begin
                        xfer_count <= xfer_count + 16'd1;
                        state      <= disp_idle;
                    end
                end
                default: state <= disp_idle;
            endcase
        end
    end

endmodule

//--- design/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int depth_log2 = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int depth = 1 << depth_log2;

    payload_t              mem [depth];
    logic [depth_log2-1:0] wr_ptr;
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count; // one bit wider so a full buffer can be told from an empty one
    logic                  do_push;
    logic                  do_pop;

    // count reaches depth exactly when its top bit is set
    assign full    = count[depth_log2];
    assign empty   = (count == '0);
    assign do_push = push && !full; // pushes into a full buffer are lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // read data shows up the cycle after the pop and stays until the next one
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

//--- design/avalon_mm_if.sv
interface avalon_mm_if ();
    import avalon_pkg::*;

    bus_addr_t  address;
    bus_word_t  writedata;
    logic       write;
    burst_cnt_t burstcount;
    logic       waitrequest; // a beat only counts while this is low

    modport master (
        output address,
        output writedata,
        output write,
        output burstcount,
        input  waitrequest
    );

    modport slave (
        input  address,
        input  writedata,
        input  write,
        input  burstcount,
        output waitrequest
    );

endinterface

//--- design/dma_pkg.sv
package dma_pkg;

    // transfer descriptor in the order software fills it, control word on top
    typedef struct packed {
        logic [31:0] control;
        logic [31:0] pkt_begin;     // byte offset of the first payload byte
        logic [31:0] pkt_end;       // byte offset just past the last payload byte
        logic [31:0] write_address; // destination of the first beat
    } wr_desc_t;

    // bit in the control word that asks for an interrupt pulse at completion
    localparam int CTRL_IRQ_EN = 0;

    // burst writer states
    typedef enum logic [1:0] {
        st_idle,
        st_run,  // beats are being handed to the slave
        st_done  // one cycle of completion signalling
    } wr_state_t;

endpackage

//--- design/avalon_pkg.sv
`include "dma_macros.svh"

package avalon_pkg;

    // one data beat on the host bus
    typedef logic [`DATA_W-1:0] bus_word_t;

    typedef logic [31:0] bus_addr_t;          // byte address of the first beat
    typedef logic [`BURST_W-1:0] burst_cnt_t; // number of beats in a burst

    // byte offsets are turned into beat counts with this
    localparam int BYTES_PER_WORD = `DATA_W / 8;

endpackage

//--- design/dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// width of one host bus word and of every word in the data FIFO
`define DATA_W 32

// burstcount width as seen on the Avalon-MM port
`define BURST_W 16

// one descriptor never asks for more words than this
`define MAX_BURST 255

// queue depths as log2 of the number of entries
`define DATA_FIFO_LOG2 4
`define DESC_FIFO_LOG2 2

`endif
